//--- sources.f
imuldiv_pkg.sv
imuldiv_unit_if.sv
imuldiv_mul_iterative.sv
imuldiv_div_iterative.sv
imuldiv_dispatch.sv
imuldiv_top.sv
tb_imuldiv.sv

//--- Makefile
# Verilator lint and simulation for the mul/div unit
# override on the command line, e.g. make sim WIDTH=16 LOG=run16.log

VERILATOR ?= verilator
TOP       ?= tb_imuldiv
WIDTH     ?= 32
LOG       ?= sim.log
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP) -GWIDTH=$(WIDTH)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
	  -GWIDTH=$(WIDTH) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_imuldiv.sv
// ----------------------------------------------------------------------
// table-driven testbench for imuldiv_top with one request in flight at a time
// random operands assume WIDTH <= 64
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_imuldiv #(
  parameter int WIDTH = 32
);

  localparam int NUM_FIXED = 18;
  localparam int NUM_RAND  = 24;
  localparam int NUM_TESTS = NUM_FIXED + NUM_RAND;
  localparam int PERIOD    = 8;
  localparam int MAX_BP    = 5;

  logic               clk;
  logic               reset;
  logic               req_val;
  logic               req_rdy;
  imuldiv_pkg::op_e   req_op;
  logic [WIDTH-1:0]   req_a;
  logic [WIDTH-1:0]   req_b;
  logic               resp_val;
  logic               resp_rdy;
  logic [2*WIDTH-1:0] resp_result;

  // stimulus table whose expected column comes from the reference model
  imuldiv_pkg::op_e   op_tab  [NUM_TESTS];
  logic [WIDTH-1:0]   a_tab   [NUM_TESTS];
  logic [WIDTH-1:0]   b_tab   [NUM_TESTS];
  logic [2*WIDTH-1:0] exp_tab [NUM_TESTS];
  int                 n_entries;
  int                 pass_count;
  int                 fail_count;
  int                 errors;
  int unsigned        seed_ret;

  imuldiv_top #(.WIDTH(WIDTH)) imuldiv_top_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #(PERIOD / 2) clk = ~clk;

  // watchdog sized from the table length
  initial begin
    #(NUM_TESTS * (2 * WIDTH + 16) * PERIOD);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * (2 * WIDTH + 16));
    $display("=== FAIL ===");
    $finish;
  end

  // ----------------------------------------------------------------------
  // reference model and table
  // ----------------------------------------------------------------------

  // result is the product or {remainder, quotient}
  function automatic logic [2*WIDTH-1:0] model(imuldiv_pkg::op_e op,
                                               logic [WIDTH-1:0] a, logic [WIDTH-1:0] b);
    logic signed [2*WIDTH-1:0] sa;
    logic signed [2*WIDTH-1:0] sb;
    logic [WIDTH-1:0]          q;
    logic [WIDTH-1:0]          r;
    logic [WIDTH-1:0]          min_neg;
    min_neg = {1'b1, {(WIDTH-1){1'b0}}};
    sa = {{WIDTH{a[WIDTH-1]}}, a};
    sb = {{WIDTH{b[WIDTH-1]}}, b};
    q  = '0;
    r  = '0;
    case (op)
      imuldiv_pkg::OP_MUL:  return sa * sb;
      imuldiv_pkg::OP_MULU: return {{WIDTH{1'b0}}, a} * {{WIDTH{1'b0}}, b};
      imuldiv_pkg::OP_DIV: begin
        if (b == '0) begin
          q = '1;
          r = a;
        end else if (a == min_neg && b == '1) begin
          // overflow wraps the quotient to the most negative value
          q = min_neg;
          r = '0;
        end else begin
          // truncating divide with the remainder carrying the dividend's sign
          q = WIDTH'(sa / sb);
          r = WIDTH'(sa % sb);
        end
      end
      default: begin
        q = (b == '0) ? '1 : a / b;
        r = (b == '0) ? a : a % b;
      end
    endcase
    return {r, q};
  endfunction

  task automatic add_entry(input imuldiv_pkg::op_e op, input logic [WIDTH-1:0] a,
                           input logic [WIDTH-1:0] b);
    op_tab[n_entries]  = op;
    a_tab[n_entries]   = a;
    b_tab[n_entries]   = b;
    exp_tab[n_entries] = model(op, a, b);
    n_entries++;
  endtask

  function automatic logic [WIDTH-1:0] rand_word();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[WIDTH-1:0];
  endfunction

  task automatic build_table();
    logic [WIDTH-1:0] min_neg;
    logic [WIDTH-1:0] b;
    imuldiv_pkg::op_e op;
    min_neg = {1'b1, {(WIDTH-1){1'b0}}};
    // multiply corners with mixed signs, the most negative value, zero and unsigned all ones
    add_entry(imuldiv_pkg::OP_MUL,  WIDTH'(3),   WIDTH'(-5));
    add_entry(imuldiv_pkg::OP_MUL,  WIDTH'(-7),  WIDTH'(-9));
    add_entry(imuldiv_pkg::OP_MUL,  min_neg,     min_neg);
    add_entry(imuldiv_pkg::OP_MUL,  min_neg,     '1);
    add_entry(imuldiv_pkg::OP_MUL,  '0,          WIDTH'(12345));
    add_entry(imuldiv_pkg::OP_MULU, '1,          '1);
    add_entry(imuldiv_pkg::OP_MULU, '1,          WIDTH'(2));
    add_entry(imuldiv_pkg::OP_MULU, '0,          '1);
    add_entry(imuldiv_pkg::OP_MULU, min_neg,     WIDTH'(3));
    // divide corners for the remainder sign, overflow and a zero divisor
    add_entry(imuldiv_pkg::OP_DIV,  WIDTH'(-7),  WIDTH'(2));
    add_entry(imuldiv_pkg::OP_DIV,  WIDTH'(7),   WIDTH'(-2));
    add_entry(imuldiv_pkg::OP_DIV,  min_neg,     '1);
    add_entry(imuldiv_pkg::OP_DIV,  WIDTH'(5),   '0);
    add_entry(imuldiv_pkg::OP_DIV,  WIDTH'(-5),  '0);
    add_entry(imuldiv_pkg::OP_DIVU, '1,          WIDTH'(3));
    add_entry(imuldiv_pkg::OP_DIVU, WIDTH'(100), '0);
    add_entry(imuldiv_pkg::OP_DIVU, WIDTH'(7),   WIDTH'(9));
    add_entry(imuldiv_pkg::OP_DIVU, min_neg,     '1);
    while (n_entries < NUM_TESTS) begin
      op = imuldiv_pkg::op_e'($urandom % 4);
      // random divisor length so quotients are not always tiny
      b  = rand_word() >> ($urandom % WIDTH);
      add_entry(op, rand_word(), b);
    end
  endtask

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------

  task automatic check_product(input imuldiv_pkg::op_e op, input logic [2*WIDTH-1:0] got,
                               input logic [2*WIDTH-1:0] exp, output bit ok);
    ok = (got === exp);
    if (!ok)
      $display("error %0t: %s product %h, expected %h", $time, op.name(), got, exp);
  endtask

  task automatic check_divide(input imuldiv_pkg::op_e op,
                              input logic [WIDTH-1:0] got_q, input logic [WIDTH-1:0] got_r,
                              input logic [WIDTH-1:0] exp_q, input logic [WIDTH-1:0] exp_r,
                              output bit ok);
    ok = (got_q === exp_q) && (got_r === exp_r);
    if (!ok)
      $display("error %0t: %s quotient %h remainder %h, expected %h and %h",
               $time, op.name(), got_q, got_r, exp_q, exp_r);
  endtask

  // ----------------------------------------------------------------------
  // one request and its response, with random back-pressure
  // ----------------------------------------------------------------------

  task automatic run_test(input int idx, output bit ok);
    int                 edges;
    int                 bp;
    logic [2*WIDTH-1:0] held;
    bit                 val_ok;
    bit                 is_div;
    ok     = 1'b1;
    is_div = (op_tab[idx] == imuldiv_pkg::OP_DIV) || (op_tab[idx] == imuldiv_pkg::OP_DIVU);
    @(posedge clk);
    req_val <= 1'b1;
    req_op  <= op_tab[idx];
    req_a   <= a_tab[idx];
    req_b   <= b_tab[idx];
    // transfer happens on the first edge that sees req_rdy high
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    req_val <= 1'b0;
    // opcode now selects the idle unit, so req_rdy reflects only the busy flag
    if (is_div)
      req_op <= imuldiv_pkg::OP_MULU;
    else
      req_op <= imuldiv_pkg::OP_DIVU;
    // count edges from the transfer edge up to resp_val
    edges = 1;
    @(negedge clk);
    while (!resp_val) begin
      if (req_rdy) begin
        $display("error %0t: req_rdy high while a request is in flight", $time);
        ok = 1'b0;
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (edges != WIDTH + 1) begin
      $display("error %0t: resp_val after %0d edges, expected %0d", $time, edges, WIDTH + 1);
      ok = 1'b0;
    end
    held = resp_result;
    bp   = $urandom % (MAX_BP + 1);
    repeat (bp) begin
      @(posedge clk);
      @(negedge clk);
      if (!resp_val || req_rdy || resp_result !== held) begin
        $display("error %0t: response not held under back-pressure", $time);
        ok = 1'b0;
      end
    end
    @(posedge clk);
    resp_rdy <= 1'b1;
    @(posedge clk);
    resp_rdy <= 1'b0;
    // unit back in IDLE one cycle after the response transfer
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      $display("error %0t: req_rdy=%b resp_val=%b after response, expected 1 and 0",
               $time, req_rdy, resp_val);
      ok = 1'b0;
    end
    if (!is_div)
      check_product(op_tab[idx], held, exp_tab[idx], val_ok);
    else
      check_divide(op_tab[idx], held[WIDTH-1:0], held[2*WIDTH-1:WIDTH],
                   exp_tab[idx][WIDTH-1:0], exp_tab[idx][2*WIDTH-1:WIDTH], val_ok);
    ok = ok && val_ok;
    $display("test %0d %s a=%h b=%h result=%h %s", idx, op_tab[idx].name(),
             a_tab[idx], b_tab[idx], held, ok ? "ok" : "failed");
  endtask

  initial begin
    bit ok;
    seed_ret   = $urandom(68968);
    clk        = 1'b0;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_op     = imuldiv_pkg::OP_MUL;
    req_a      = '0;
    req_b      = '0;
    resp_rdy   = 1'b0;
    n_entries  = 0;
    pass_count = 0;
    fail_count = 0;
    errors     = 0;
    build_table();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // idle outputs before the first request
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      $display("error %0t: after reset req_rdy=%b resp_val=%b, expected 1 and 0",
               $time, req_rdy, resp_val);
      errors++;
    end
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i, ok);
      if (ok)
        pass_count++;
      else
        fail_count++;
    end
    $display("tests passed %0d failed %0d, other errors %0d", pass_count, fail_count, errors);
    if (fail_count == 0 && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- imuldiv_top.sv
// ----------------------------------------------------------------------
// mul/div unit top, valid/ready request and response ports
// WIDTH even and >= 8, result is 2*WIDTH bits
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_top #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  imuldiv_pkg::op_e   req_op,
  input  logic [WIDTH-1:0]   req_a,
  input  logic [WIDTH-1:0]   req_b,
  output logic               resp_val,
  input  logic               resp_rdy,
  output logic [2*WIDTH-1:0] resp_result
);

  // one bus per iterative unit
  imuldiv_unit_if #(.WIDTH(WIDTH)) mul_bus ();
  imuldiv_unit_if #(.WIDTH(WIDTH)) div_bus ();

  imuldiv_dispatch #(.WIDTH(WIDTH)) dispatch (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .mul         (mul_bus),
    .div         (div_bus)
  );

  imuldiv_mul_iterative #(.WIDTH(WIDTH)) mul_unit (.clk(clk), .reset(reset), .bus(mul_bus));

  imuldiv_div_iterative #(.WIDTH(WIDTH)) div_unit (.clk(clk), .reset(reset), .bus(div_bus));

endmodule

//--- imuldiv_dispatch.sv
// ----------------------------------------------------------------------
// routes one request at a time to the mul or div unit by opcode
// busy from request transfer until response transfer
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_dispatch #(
  parameter int WIDTH = 32
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  output logic                req_rdy,
  input  imuldiv_pkg::op_e    req_op,
  input  logic [WIDTH-1:0]    req_a,
  input  logic [WIDTH-1:0]    req_b,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [2*WIDTH-1:0]  resp_result,
  imuldiv_unit_if.dispatch    mul,
  imuldiv_unit_if.dispatch    div
);

  logic use_div;
  logic op_signed;
  logic busy;
  // unit that owns the current op, 1 = divider
  logic active_div;

  // opcode decode
  assign use_div   = (req_op == imuldiv_pkg::OP_DIV) || (req_op == imuldiv_pkg::OP_DIVU);
  assign op_signed = (req_op == imuldiv_pkg::OP_MUL) || (req_op == imuldiv_pkg::OP_DIV);

  // request fan-out, val only to the selected unit and never while busy
  assign mul.req_val    = req_val && !busy && !use_div;
  assign div.req_val    = req_val && !busy && use_div;
  assign mul.req_signed = op_signed;
  assign div.req_signed = op_signed;
  assign mul.a          = req_a;
  assign mul.b          = req_b;
  assign div.a          = req_a;
  assign div.b          = req_b;

  assign req_rdy = !busy && (use_div ? div.req_rdy : mul.req_rdy);

  // response steering from the active unit only
  assign resp_val     = busy && (active_div ? div.resp_val : mul.resp_val);
  assign resp_result  = active_div ? div.result : mul.result;
  assign mul.resp_rdy = busy && !active_div && resp_rdy;
  assign div.resp_rdy = busy && active_div && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      active_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy       <= 1'b1;
      active_div <= use_div;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

  // neither unit may take a request while the other one is still owed
  a_no_req_while_busy: assert property (@(posedge clk) disable iff (reset)
    busy |-> !(mul.req_val && mul.req_rdy) && !(div.req_val && div.req_rdy));

endmodule

//--- imuldiv_div_iterative.sv
// ----------------------------------------------------------------------
// restoring divider, WIDTH cycles per op, one op in flight
// x/0 gives all-ones quotient and remainder = dividend
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_div_iterative #(
  parameter int WIDTH = 32
) (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.unit bus
);

  localparam int CW = $clog2(WIDTH);

  imuldiv_pkg::state_e state;
  imuldiv_pkg::state_e state_next;

  logic [CW-1:0]    count;
  // partial remainder, and dividend bits shifting out as quotient shifts in
  logic [WIDTH-1:0] rem_reg;
  logic [WIDTH-1:0] quo_reg;
  logic [WIDTH-1:0] dvs_reg;
  logic             neg_q;
  logic             neg_r;
  logic             div_zero;

  logic             req_go;
  logic             resp_go;
  logic [WIDTH-1:0] mag_a;
  logic [WIDTH-1:0] mag_b;
  logic [WIDTH:0]   shifted;
  logic [WIDTH:0]   diff;
  logic [WIDTH-1:0] quo_out;
  logic [WIDTH-1:0] rem_out;

  assign req_go  = bus.req_val && bus.req_rdy;
  assign resp_go = bus.resp_val && bus.resp_rdy;

  assign mag_a = (bus.req_signed && bus.a[WIDTH-1]) ? (~bus.a + 1'b1) : bus.a;
  assign mag_b = (bus.req_signed && bus.b[WIDTH-1]) ? (~bus.b + 1'b1) : bus.b;

  // bring down the next dividend bit and trial-subtract the divisor
  // the extra top bit of diff is the borrow
  assign shifted = {rem_reg, quo_reg[WIDTH-1]};
  assign diff    = shifted - {1'b0, dvs_reg};

  // ----------------------------------------------------------------------
  // controller
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::IDLE: if (req_go) state_next = imuldiv_pkg::CALC;
      imuldiv_pkg::CALC: if (count == '0) state_next = imuldiv_pkg::DONE;
      imuldiv_pkg::DONE: if (resp_go) state_next = imuldiv_pkg::IDLE;
      default:           state_next = imuldiv_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        count <= CW'(WIDTH - 1);
      end else if (state == imuldiv_pkg::CALC && count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      rem_reg  <= '0;
      quo_reg  <= mag_a;
      dvs_reg  <= mag_b;
      neg_q    <= bus.req_signed && (bus.a[WIDTH-1] ^ bus.b[WIDTH-1]);
      // remainder follows the dividend's sign
      neg_r    <= bus.req_signed && bus.a[WIDTH-1];
      div_zero <= (bus.b == '0);
    end else if (state == imuldiv_pkg::CALC) begin
      if (!diff[WIDTH]) begin
        // no borrow, keep the difference
        rem_reg <= diff[WIDTH-1:0];
        quo_reg <= {quo_reg[WIDTH-2:0], 1'b1};
      end else begin
        // borrow, restore
        rem_reg <= shifted[WIDTH-1:0];
        quo_reg <= {quo_reg[WIDTH-2:0], 1'b0};
      end
    end
  end

  // with a zero divisor every step succeeds, so the remainder magnitude is
  // the dividend magnitude and the sign fix gives back the dividend
  // only the quotient sign has to be overridden
  assign quo_out = div_zero ? '1 : (neg_q ? (~quo_reg + 1'b1) : quo_reg);
  assign rem_out = neg_r ? (~rem_reg + 1'b1) : rem_reg;

  assign bus.req_rdy  = (state == imuldiv_pkg::IDLE);
  assign bus.resp_val = (state == imuldiv_pkg::DONE);
  assign bus.result   = {rem_out, quo_out};

  a_div_one_in_flight: assert property (@(posedge clk) disable iff (reset)
    !(bus.resp_val && bus.req_rdy));

endmodule

//--- imuldiv_mul_iterative.sv
// ----------------------------------------------------------------------
// shift-and-add multiplier taking WIDTH cycles per product with one op in flight
// signed ops multiply magnitudes and fix the sign in DONE
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_mul_iterative #(
  parameter int WIDTH = 32
) (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.unit bus
);

  localparam int CW = $clog2(WIDTH);

  imuldiv_pkg::state_e state;
  imuldiv_pkg::state_e state_next;

  logic [CW-1:0]      count;
  logic [2*WIDTH-1:0] a_reg;
  logic [WIDTH-1:0]   b_reg;
  logic [2*WIDTH-1:0] acc;
  logic               neg;

  logic               req_go;
  logic               resp_go;
  logic [WIDTH-1:0]   mag_a;
  logic [WIDTH-1:0]   mag_b;

  assign req_go  = bus.req_val && bus.req_rdy;
  assign resp_go = bus.resp_val && bus.resp_rdy;

  // magnitude only for a signed, negative operand
  // the most negative value maps onto itself, which is the right magnitude
  assign mag_a = (bus.req_signed && bus.a[WIDTH-1]) ? (~bus.a + 1'b1) : bus.a;
  assign mag_b = (bus.req_signed && bus.b[WIDTH-1]) ? (~bus.b + 1'b1) : bus.b;

  // ----------------------------------------------------------------------
  // controller
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::IDLE: if (req_go) state_next = imuldiv_pkg::CALC;
      // counter was loaded with WIDTH-1, so CALC lasts WIDTH cycles
      imuldiv_pkg::CALC: if (count == '0) state_next = imuldiv_pkg::DONE;
      imuldiv_pkg::DONE: if (resp_go) state_next = imuldiv_pkg::IDLE;
      default:           state_next = imuldiv_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        count <= CW'(WIDTH - 1);
      end else if (state == imuldiv_pkg::CALC && count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      a_reg <= {{WIDTH{1'b0}}, mag_a};
      b_reg <= mag_b;
      acc   <= '0;
      // product is negative only when exactly one signed operand was
      neg   <= bus.req_signed && (bus.a[WIDTH-1] ^ bus.b[WIDTH-1]);
    end else if (state == imuldiv_pkg::CALC) begin
      // add the shifted multiplicand for each set multiplier bit
      if (b_reg[0]) begin
        acc <= acc + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // registers are frozen in DONE, so result holds under back-pressure
  assign bus.req_rdy  = (state == imuldiv_pkg::IDLE);
  assign bus.resp_val = (state == imuldiv_pkg::DONE);
  assign bus.result   = neg ? (~acc + 1'b1) : acc;

  // a response and a new request never overlap
  a_mul_one_in_flight: assert property (@(posedge clk) disable iff (reset)
    !(bus.resp_val && bus.req_rdy));

  // DONE follows exactly WIDTH cycles of CALC with the bit counter run out
  a_mul_count_done: assert property (@(posedge clk) disable iff (reset)
    $rose(state == imuldiv_pkg::DONE) |->
      ($past(count) == '0) && $past(state == imuldiv_pkg::CALC, WIDTH) &&
      $past(state == imuldiv_pkg::IDLE, WIDTH + 1));

endmodule

//--- imuldiv_unit_if.sv
// ----------------------------------------------------------------------
// request and response handshakes between dispatch and one unit
// ----------------------------------------------------------------------
`timescale 1ns/1ns

interface imuldiv_unit_if #(
  parameter int WIDTH = 32
);

  // request side
  logic               req_val;
  logic               req_rdy;
  logic               req_signed;
  logic [WIDTH-1:0]   a;
  logic [WIDTH-1:0]   b;

  // response side
  logic               resp_val;
  logic               resp_rdy;
  logic [2*WIDTH-1:0] result;

  modport dispatch (
    output req_val, req_signed, a, b, resp_rdy,
    input  req_rdy, resp_val, result
  );

  modport unit (
    input  req_val, req_signed, a, b, resp_rdy,
    output req_rdy, resp_val, result
  );

endinterface

//--- imuldiv_pkg.sv
// ----------------------------------------------------------------------
// opcodes and controller states shared by dispatch and both units
// ----------------------------------------------------------------------
package imuldiv_pkg;

  // request opcodes
  // signed forms treat operands as two's complement
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_MULU = 2'd1,
    OP_DIV  = 2'd2,
    OP_DIVU = 2'd3
  } op_e;

  // iterative unit controller
  // IDLE waits for a request, CALC runs one bit per cycle,
  // DONE holds the result until the response is taken
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } state_e;

endpackage
